/* kmac_ctrl.f */
source/kmac_ctrl_pkg.sv
source/kmac_err_pkg.sv
source/kmac_cmd_buf.sv
source/kmac_ctrl_fsm.sv
source/kmac_event_report.sv
source/kmac_ctrl_top.sv
tb/kmac_ctrl_chk.sv
tb/tb_kmac_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the KMAC control core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_kmac_ctrl -f kmac_ctrl.f

out=$(./obj_dir/Vtb_kmac_ctrl)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* tb/tb_kmac_ctrl.sv */
// Testbench for the KMAC control core.
// Drives command writes, engine status, FIFO level, errors and interrupt
// controls, and compares every cycle with a cycle model kept here.

`timescale 1ns/1ps

module tb_kmac_ctrl;

  import kmac_ctrl_pkg::*;
  import kmac_err_pkg::*;

  localparam int NumRand   = 300;
  localparam int NumCmds   = NumRand + 5;
  localparam int MaxCycles = NumCmds * 40 + 200;

  typedef enum logic [2:0] {MIdle, MPrefix, MKey, MMsg, MDigest} model_st_e;

  logic         clk_i;
  logic         rst_ni;
  logic         cmd_wr_i;
  kmac_cmd_e    cmd_i;
  ctrl_cfg_t    cfg_i;
  engine_stat_t engine_i;
  logic         fifo_empty_i;
  err_src_t     err_i;
  intr_vec_t    intr_enable_i;
  intr_vec_t    intr_test_i;
  intr_vec_t    intr_clr_i;
  sha3_ctrl_t   sha3_ctrl_o;
  logic         in_keyblock_o;
  logic         fsm_error_o;
  logic         idle_o;
  intr_vec_t    intr_state_o;
  intr_vec_t    intr_o;
  err_word_u    err_code_o;

  // Command model, current entry with countdown and one buffered entry
  logic        cur_valid;
  kmac_cmd_e   cur_cmd;
  int unsigned cur_wait;
  logic        buf_valid;
  kmac_cmd_e   buf_cmd;

  // FSM, idle, interrupt and error model
  model_st_e m_st;
  logic      m_idle;
  logic      m_fifo_prev;
  intr_vec_t m_state;
  intr_vec_t m_intr;
  err_word_u m_err;

  // Engine responder
  sha3_st_e    eng_phase;
  int unsigned blk_left;
  int unsigned blk_timer;
  logic        abs_armed;
  int unsigned abs_timer;

  // Requests applied at the next falling edge
  logic      wr_req;
  kmac_cmd_e wr_cmd;
  ctrl_cfg_t cfg_req;

  kmac_cmd_e cmd_pick [4] = '{CmdStart, CmdProcess, CmdManualRun, CmdDone};

  int unsigned n_checks;
  int unsigned n_ctrl_err;
  int unsigned n_intr_err;
  int unsigned n_word_err;
  int unsigned n_bit_err;

  kmac_ctrl_top kmac_ctrl_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_wr_i      (cmd_wr_i),
    .cmd_i         (cmd_i),
    .cfg_i         (cfg_i),
    .engine_i      (engine_i),
    .fifo_empty_i  (fifo_empty_i),
    .err_i         (err_i),
    .intr_enable_i (intr_enable_i),
    .intr_test_i   (intr_test_i),
    .intr_clr_i    (intr_clr_i),
    .sha3_ctrl_o   (sha3_ctrl_o),
    .in_keyblock_o (in_keyblock_o),
    .fsm_error_o   (fsm_error_o),
    .idle_o        (idle_o),
    .intr_state_o  (intr_state_o),
    .intr_o        (intr_o),
    .err_code_o    (err_code_o)
  );

  bind kmac_ctrl_top kmac_ctrl_chk u_ctrl_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sha3_ctrl_o  (sha3_ctrl_o),
    .intr_state_o (intr_state_o),
    .intr_o       (intr_o),
    .fsm_error_o  (fsm_error_o),
    .idle_o       (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic expect_ctrl(input string name, input sha3_ctrl_t got, input sha3_ctrl_t exp);
    n_checks++;
    if (got !== exp) begin
      n_ctrl_err++;
      $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic match_intr(input string name, input intr_vec_t got, input intr_vec_t exp);
    n_checks++;
    if (got !== exp) begin
      n_intr_err++;
      $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input err_word_u got, input err_word_u exp);
    n_checks++;
    if (got.raw !== exp.raw) begin
      n_word_err++;
      $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_bit_err++;
      $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic sha3_ctrl_t pulses_for(input kmac_cmd_e c);
    sha3_ctrl_t p;
    p = '0;
    case (c)
      CmdStart:     p.start   = 1'b1;
      CmdProcess:   p.process = 1'b1;
      CmdManualRun: p.run     = 1'b1;
      CmdDone:      p.done    = 1'b1;
      default:      p = '0;
    endcase
    return p;
  endfunction

  // Manual run skips the wait
  function automatic int unsigned delay_of(input kmac_cmd_e c);
    return (c == CmdManualRun) ? 0 : CmdDelay;
  endfunction

  function automatic sha3_ctrl_t expected_ctrl();
    if (cur_valid && cur_wait == 0) begin
      return pulses_for(cur_cmd);
    end
    return '0;
  endfunction

  task automatic model_step();
    sha3_ctrl_t p;
    err_t       src [4];
    intr_vec_t  ev;
    logic       issue;
    p     = expected_ctrl();
    issue = cur_valid && (cur_wait == 0);

    case (m_st)
      MIdle: if (p.start) m_st = cfg_i.cshake_en ? MPrefix : MMsg;
      MPrefix: if (engine_i.block_processed) m_st = cfg_i.kmac_en ? MKey : MMsg;
      MKey: if (engine_i.block_processed) m_st = MMsg;
      MMsg: if (engine_i.absorbed) m_st = p.done ? MIdle : MDigest;
      default: if (p.done) m_st = MIdle;
    endcase
    m_idle = (engine_i.phase == StIdle) && fifo_empty_i;

    // FIFO drain counts on the rising edge only
    src           = '{err_i.app, err_i.errchk, err_i.sha3, err_i.entropy};
    ev.kmac_done  = engine_i.absorbed;
    ev.fifo_empty = fifo_empty_i && !m_fifo_prev;
    ev.kmac_err   = src[0].valid || src[1].valid || src[2].valid || src[3].valid;
    m_fifo_prev   = fifo_empty_i;
    m_intr        = intr_vec_t'(m_state & intr_enable_i);
    m_state       = intr_vec_t'((m_state & ~intr_clr_i) | ev | intr_test_i);

    // Lowest priority first so the top source is written last
    for (int i = 3; i >= 0; i--) begin
      if (src[i].valid) begin
        m_err.fields.code = src[i].code;
        m_err.fields.info = src[i].info;
      end
    end

    // Issued entry leaves and the buffer moves up
    if (issue) begin
      cur_valid = buf_valid;
      cur_cmd   = buf_cmd;
      cur_wait  = delay_of(buf_cmd);
      buf_valid = 1'b0;
    end else if (cur_valid) begin
      cur_wait--;
    end
    if (cmd_wr_i) begin
      if (!cur_valid) begin
        cur_valid = 1'b1;
        cur_cmd   = cmd_i;
        cur_wait  = delay_of(cmd_i);
      end else begin
        buf_valid = 1'b1;
        buf_cmd   = cmd_i;
      end
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Engine answers to the pulses of the current cycle
  task automatic drive_engine();
    engine_stat_t e;
    sha3_ctrl_t   p;
    e       = '0;
    e.phase = eng_phase;
    p       = expected_ctrl();
    if (blk_left > 0) begin
      if (blk_timer == 0) begin
        e.block_processed = 1'b1;
        blk_left--;
        blk_timer = $urandom_range(1, 5);
      end else begin
        blk_timer--;
      end
    end else if (abs_armed) begin
      // Message absorbed only after prefix and key blocks
      if (abs_timer == 0) begin
        e.absorbed = 1'b1;
        abs_armed  = 1'b0;
        eng_phase  = StSqueeze;
      end else begin
        abs_timer--;
      end
    end
    if (p.start) begin
      eng_phase = StAbsorb;
      blk_left  = cfg_i.cshake_en ? (cfg_i.kmac_en ? 2 : 1) : 0;
      blk_timer = $urandom_range(1, 5);
    end
    if (p.process) begin
      abs_armed = 1'b1;
      abs_timer = $urandom_range(1, 7);
    end
    if (p.done) begin
      eng_phase = StIdle;
    end
    engine_i = e;
  endtask

  task automatic drive_misc();
    err_t src [4];
    if ($urandom_range(0, 5) == 0) begin
      fifo_empty_i = !fifo_empty_i;
    end
    // Invalid sources still carry junk codes
    for (int i = 0; i < 4; i++) begin
      src[i].valid = ($urandom_range(0, 19) == 0);
      src[i].code  = err_code_e'(8'($urandom_range(0, 8)));
      src[i].info  = 24'($urandom);
    end
    err_i.app     = src[0];
    err_i.errchk  = src[1];
    err_i.sha3    = src[2];
    err_i.entropy = src[3];
    intr_test_i = '0;
    if ($urandom_range(0, 24) == 0) begin
      intr_test_i = intr_vec_t'(3'($urandom_range(1, 7)));
    end
    intr_clr_i = '0;
    if ($urandom_range(0, 7) == 0) begin
      intr_clr_i = intr_vec_t'(3'($urandom_range(1, 7)));
    end
    if ($urandom_range(0, 29) == 0) begin
      intr_enable_i = intr_vec_t'(3'($urandom_range(0, 7)));
    end
  endtask

  task automatic compare_outputs();
    expect_ctrl("sha3_ctrl_o", sha3_ctrl_o, expected_ctrl());
    compare_bit("in_keyblock_o", in_keyblock_o, m_st == MKey);
    compare_bit("fsm_error_o", fsm_error_o, 1'b0);
    compare_bit("idle_o", idle_o, m_idle);
    match_intr("intr_state_o", intr_state_o, m_state);
    match_intr("intr_o", intr_o, m_intr);
    check_err("err_code_o", err_code_o, m_err);
  endtask

  // Outputs are settled from the rising edge, then the next inputs go out
  task automatic drive_cycle();
    compare_outputs();
    cmd_wr_i = wr_req;
    cmd_i    = wr_req ? wr_cmd : CmdNone;
    wr_req   = 1'b0;
    cfg_i    = cfg_req;
    drive_misc();
    drive_engine();
    model_step();
  endtask

  task automatic tick();
    @(negedge clk_i);
    drive_cycle();
  endtask

  task automatic write_cmd(input kmac_cmd_e c);
    wr_req = 1'b1;
    wr_cmd = c;
    tick();
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) tick();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'ha568));
    rst_ni        = 1'b0;
    cmd_wr_i      = 1'b0;
    cmd_i         = CmdNone;
    cfg_i         = '0;
    engine_i      = '0;
    fifo_empty_i  = 1'b1;
    err_i         = '0;
    intr_enable_i = '1;
    intr_test_i   = '0;
    intr_clr_i    = '0;
    cur_valid     = 1'b0;
    cur_cmd       = CmdNone;
    cur_wait      = 0;
    buf_valid     = 1'b0;
    buf_cmd       = CmdNone;
    m_st          = MIdle;
    m_idle        = 1'b1;
    m_fifo_prev   = 1'b1;
    m_state       = '0;
    m_intr        = '0;
    m_err         = '0;
    eng_phase     = StIdle;
    blk_left      = 0;
    blk_timer     = 0;
    abs_armed     = 1'b0;
    abs_timer     = 0;
    wr_req        = 1'b0;
    wr_cmd        = CmdNone;
    cfg_req       = '0;
    n_checks      = 0;
    n_ctrl_err    = 0;
    n_intr_err    = 0;
    n_word_err    = 0;
    n_bit_err     = 0;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    drive_cycle();

    // KMAC run, manual run buffered then replaced by process
    cfg_req.kmac_en   = 1'b1;
    cfg_req.cshake_en = 1'b1;
    write_cmd(CmdStart);
    tick();
    write_cmd(CmdManualRun);
    tick();
    write_cmd(CmdProcess);
    wait_cycles(40);
    write_cmd(CmdDone);
    wait_cycles(10);
    compare_bit("fsm_state_idle", kmac_ctrl_top_i.u_ctrl_fsm.st_q == KmacIdle, 1'b1);
    write_cmd(CmdManualRun);
    wait_cycles(3);

    // Random commands, gaps short enough to hit the buffer
    for (int n = 0; n < NumRand; n++) begin
      if ($urandom_range(0, 3) == 0) begin
        cfg_req = ctrl_cfg_t'(2'($urandom_range(0, 3)));
      end
      write_cmd(cmd_pick[2'($urandom_range(0, 3))]);
      wait_cycles($urandom_range(0, 10));
    end
    wait_cycles(20);

    $display("Checks %0d, errors: sha3_ctrl %0d, intr %0d, err_code %0d, levels %0d",
             n_checks, n_ctrl_err, n_intr_err, n_word_err, n_bit_err);
    if (n_ctrl_err + n_intr_err + n_word_err + n_bit_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (MaxCycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", MaxCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tb/kmac_ctrl_chk.sv */
// Assertions on the KMAC control core top level.
// Bound into kmac_ctrl_top from the testbench.

`timescale 1ns/1ps

module kmac_ctrl_chk (
  input logic                      clk_i,
  input logic                      rst_ni,
  input kmac_ctrl_pkg::sha3_ctrl_t sha3_ctrl_o,
  input kmac_ctrl_pkg::intr_vec_t  intr_state_o,
  input kmac_ctrl_pkg::intr_vec_t  intr_o,
  input logic                      fsm_error_o,
  input logic                      idle_o
);

  // One engine pulse per cycle at most
  a_ctrl_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(4'(sha3_ctrl_o)))
    else $error("sha3_ctrl_o carries more than one pulse");

  // Interrupt line needs its state bit in the cycle before
  a_intr_from_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (3'(intr_o) & ~3'($past(intr_state_o))) == 3'b000)
    else $error("intr_o high without a matching state bit one cycle earlier");

  a_no_fsm_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fsm_error_o)
    else $error("FSM reached an illegal state code");

  // Idle level holds its reset value into the first active cycle
  a_idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> idle_o)
    else $error("idle_o low in the first cycle after reset");

endmodule

/* source/kmac_ctrl_top.sv */
// Top level of the KMAC control core.
// Software commands pass through the delay buffer into the FSM; engine
// status, FIFO level and error reports feed the interrupt and error block.

`timescale 1ns/1ps

module kmac_ctrl_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Software command write
  input  logic                        cmd_wr_i,
  input  kmac_ctrl_pkg::kmac_cmd_e    cmd_i,
  input  kmac_ctrl_pkg::ctrl_cfg_t    cfg_i,
  // Engine and FIFO status
  input  kmac_ctrl_pkg::engine_stat_t engine_i,
  input  logic                        fifo_empty_i,
  input  kmac_err_pkg::err_src_t      err_i,
  // Interrupt control
  input  kmac_ctrl_pkg::intr_vec_t    intr_enable_i,
  input  kmac_ctrl_pkg::intr_vec_t    intr_test_i,
  input  kmac_ctrl_pkg::intr_vec_t    intr_clr_i,
  // Engine control and status out
  output kmac_ctrl_pkg::sha3_ctrl_t   sha3_ctrl_o,
  output logic                        in_keyblock_o,
  output logic                        fsm_error_o,
  output logic                        idle_o,
  output kmac_ctrl_pkg::intr_vec_t    intr_state_o,
  output kmac_ctrl_pkg::intr_vec_t    intr_o,
  output kmac_err_pkg::err_word_u     err_code_o
);

  import kmac_ctrl_pkg::*;

  // Issued command, none between pulses
  kmac_cmd_e cmd_issued;

  kmac_cmd_buf u_cmd_buf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cmd_wr_i (cmd_wr_i),
    .cmd_i    (cmd_i),
    .cmd_o    (cmd_issued)
  );

  kmac_ctrl_fsm u_ctrl_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_issued),
    .cfg_i         (cfg_i),
    .engine_i      (engine_i),
    .fifo_empty_i  (fifo_empty_i),
    .sha3_ctrl_o   (sha3_ctrl_o),
    .in_keyblock_o (in_keyblock_o),
    .fsm_error_o   (fsm_error_o),
    .idle_o        (idle_o)
  );

  kmac_event_report u_event_report (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .absorbed_i    (engine_i.absorbed),
    .fifo_empty_i  (fifo_empty_i),
    .err_i         (err_i),
    .intr_enable_i (intr_enable_i),
    .intr_test_i   (intr_test_i),
    .intr_clr_i    (intr_clr_i),
    .intr_state_o  (intr_state_o),
    .intr_o        (intr_o),
    .err_code_o    (err_code_o)
  );

endmodule

/* source/kmac_event_report.sv */
// Interrupt and error reporting.
// Keeps sticky interrupt state for done, FIFO drain and error events,
// drives the registered interrupt lines and latches the error code word.

`timescale 1ns/1ps

module kmac_event_report (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     absorbed_i,
  input  logic                     fifo_empty_i,
  input  kmac_err_pkg::err_src_t   err_i,
  input  kmac_ctrl_pkg::intr_vec_t intr_enable_i,
  input  kmac_ctrl_pkg::intr_vec_t intr_test_i,
  input  kmac_ctrl_pkg::intr_vec_t intr_clr_i,
  output kmac_ctrl_pkg::intr_vec_t intr_state_o,
  output kmac_ctrl_pkg::intr_vec_t intr_o,
  output kmac_err_pkg::err_word_u  err_code_o
);

  import kmac_ctrl_pkg::*;
  import kmac_err_pkg::*;

  logic      fifo_empty_q;
  logic      err_any;
  intr_vec_t event_vec;
  err_t      err_sel;

  //////////////////////////////
  // Events
  //////////////////////////////

  // Starts high so a FIFO empty out of reset is no event
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_empty_q <= 1'b1;
    end else begin
      fifo_empty_q <= fifo_empty_i;
    end
  end

  assign err_any = err_i.app.valid | err_i.errchk.valid |
                   err_i.sha3.valid | err_i.entropy.valid;

  always_comb begin
    event_vec            = '0;
    event_vec.kmac_done  = absorbed_i;
    event_vec.fifo_empty = fifo_empty_i & ~fifo_empty_q;
    event_vec.kmac_err   = err_any;
  end

  // Sticky state, set beats clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_o <= '0;
      intr_o       <= '0;
    end else begin
      intr_state_o <= intr_vec_t'((intr_state_o & ~intr_clr_i) | event_vec | intr_test_i);
      intr_o       <= intr_vec_t'(intr_state_o & intr_enable_i);
    end
  end

  //////////////////////////////
  // Error code
  //////////////////////////////

  // App first, then error checker, engine and entropy
  always_comb begin
    if (err_i.app.valid) begin
      err_sel = err_i.app;
    end else if (err_i.errchk.valid) begin
      err_sel = err_i.errchk;
    end else if (err_i.sha3.valid) begin
      err_sel = err_i.sha3;
    end else begin
      err_sel = err_i.entropy;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_code_o <= '0;
    end else if (err_any) begin
      err_code_o.fields.code <= err_sel.code;
      err_code_o.fields.info <= err_sel.info;
    end
  end

endmodule

/* source/kmac_ctrl_fsm.sv */
// Command decode and KMAC sequencing FSM.
// Turns issued commands into engine pulses, tracks prefix, key block,
// message and digest phases, and registers the idle level.

`timescale 1ns/1ps

module kmac_ctrl_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  kmac_ctrl_pkg::kmac_cmd_e    cmd_i,
  input  kmac_ctrl_pkg::ctrl_cfg_t    cfg_i,
  input  kmac_ctrl_pkg::engine_stat_t engine_i,
  input  logic                        fifo_empty_i,
  output kmac_ctrl_pkg::sha3_ctrl_t   sha3_ctrl_o,
  output logic                        in_keyblock_o,
  output logic                        fsm_error_o,
  output logic                        idle_o
);

  import kmac_ctrl_pkg::*;

  kmac_st_e st_q;
  kmac_st_e st_d;

  //////////////////////////////
  // Command decode
  //////////////////////////////

  always_comb begin
    sha3_ctrl_o = '0;
    unique case (cmd_i)
      CmdStart:     sha3_ctrl_o.start   = 1'b1;
      CmdProcess:   sha3_ctrl_o.process = 1'b1;
      CmdManualRun: sha3_ctrl_o.run     = 1'b1;
      CmdDone:      sha3_ctrl_o.done    = 1'b1;
      default: begin
        // CmdNone and unknown codes give no pulse
      end
    endcase
  end

  //////////////////////////////
  // Sequencing FSM
  //////////////////////////////

  always_comb begin
    st_d          = st_q;
    in_keyblock_o = 1'b0;
    fsm_error_o   = 1'b0;

    unique case (st_q)
      KmacIdle: begin
        // cSHAKE needs the prefix block first
        if (sha3_ctrl_o.start) begin
          st_d = cfg_i.cshake_en ? KmacPrefix : KmacMsgFeed;
        end
      end

      KmacPrefix: begin
        if (engine_i.block_processed) begin
          st_d = cfg_i.kmac_en ? KmacKeyBlock : KmacMsgFeed;
        end
      end

      KmacKeyBlock: begin
        // Secret key block in flight
        in_keyblock_o = 1'b1;
        if (engine_i.block_processed) begin
          st_d = KmacMsgFeed;
        end
      end

      KmacMsgFeed: begin
        // Absorbed with done in the same cycle skips the digest phase
        if (engine_i.absorbed) begin
          st_d = sha3_ctrl_o.done ? KmacIdle : KmacDigest;
        end
      end

      KmacDigest: begin
        // Manual runs may come here, only done leaves
        if (sha3_ctrl_o.done) begin
          st_d = KmacIdle;
        end
      end

      default: begin
        // Illegal code, stay and flag it
        st_d        = st_q;
        fsm_error_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= KmacIdle;
    end else begin
      st_q <= st_d;
    end
  end

  // Idle once the engine rests and the message FIFO has drained
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_o <= 1'b1;
    end else begin
      idle_o <= (engine_i.phase == StIdle) && fifo_empty_i;
    end
  end

endmodule

/* source/kmac_cmd_buf.sv */
// Command delay and buffer stage.
// A written command waits CmdDelay cycles before it is issued; one further
// command is held behind it. Manual run is issued as soon as it is current.

`timescale 1ns/1ps

module kmac_cmd_buf (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmd_wr_i,
  input  kmac_ctrl_pkg::kmac_cmd_e cmd_i,
  output kmac_ctrl_pkg::kmac_cmd_e cmd_o
);

  import kmac_ctrl_pkg::*;

  logic [CmdDelayW-1:0] count_q;
  logic                 pending_q;
  logic                 buf_empty;
  logic                 expire;
  kmac_cmd_e            cmd_q;
  kmac_cmd_e            cmd_buf_q;

  assign buf_empty = (cmd_buf_q == CmdNone);

  // Current command leaves on count expiry, manual run does not wait
  assign expire = pending_q &&
                  ((count_q == CmdDelayW'(CmdDelay)) || (cmd_q == CmdManualRun));

  // Issue pulse, none on every other cycle
  assign cmd_o = expire ? cmd_q : CmdNone;

  //////////////////////////////
  // Delay counter and buffer
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q   <= '0;
      pending_q <= 1'b0;
      cmd_q     <= CmdNone;
      cmd_buf_q <= CmdNone;
    end else begin
      if (!pending_q) begin
        // Nothing waiting, a write starts a new delay
        if (cmd_wr_i) begin
          cmd_q     <= cmd_i;
          count_q   <= '0;
          pending_q <= 1'b1;
        end
      end else if (expire) begin
        count_q <= '0;
        if (cmd_wr_i && buf_empty) begin
          // New write becomes current directly
          cmd_q <= cmd_i;
        end else if (cmd_wr_i) begin
          // Buffer moves up, write takes its place
          cmd_q     <= cmd_buf_q;
          cmd_buf_q <= cmd_i;
        end else begin
          cmd_q     <= cmd_buf_q;
          cmd_buf_q <= CmdNone;
          pending_q <= !buf_empty;
        end
      end else begin
        count_q <= count_q + 1'b1;
        // Later writes overwrite the buffered entry
        if (cmd_wr_i) begin
          cmd_buf_q <= cmd_i;
        end
      end
    end
  end

endmodule

/* source/kmac_err_pkg.sv */
// Error reporting types for the KMAC control core.
// Sources outside the design report through err_t; the reporter packs the
// winning source into the 32-bit code word that software reads.

package kmac_err_pkg;

  localparam int ErrInfoW = 24;

  typedef enum logic [7:0] {
    ErrNone                   = 8'h00,
    ErrKeyNotValid            = 8'h01,
    ErrSwPushedMsgFifo        = 8'h02,
    ErrSwIssuedCmdInAppActive = 8'h03,
    ErrWaitTimerExpired       = 8'h04,
    ErrIncorrectEntropyMode   = 8'h05,
    ErrUnexpectedModeStrength = 8'h06,
    ErrIncorrectFunctionName  = 8'h07,
    ErrSwCmdSequence          = 8'h08,
    ErrSha3SwControl          = 8'h80
  } err_code_e;

  typedef struct packed {
    logic                valid;
    err_code_e           code;
    logic [ErrInfoW-1:0] info;
  } err_t;

  // Code word, raw for software and split for the reporter
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      err_code_e           code;
      logic [ErrInfoW-1:0] info;
    } fields;
  } err_word_u;

  // Highest priority first
  typedef struct packed {
    err_t app;
    err_t errchk;
    err_t sha3;
    err_t entropy;
  } err_src_t;

endpackage

/* source/kmac_ctrl_pkg.sv */
// Shared types for the KMAC control core.
// Covers the software command field, the sequencing FSM state, engine status,
// configuration and interrupt vectors, and the command delay.

package kmac_ctrl_pkg;

  // Command issue delay in cycles
  localparam int CmdDelay  = 4;
  localparam int CmdDelayW = $clog2(CmdDelay + 1);

  localparam int CmdW    = 6;
  localparam int KmacStW = 6;

  // Software command field encoding
  typedef enum logic [CmdW-1:0] {
    CmdNone      = 6'b001011,
    CmdStart     = 6'b011101,
    CmdProcess   = 6'b101110,
    CmdManualRun = 6'b110001,
    CmdDone      = 6'b010110
  } kmac_cmd_e;

  // Sparse FSM encoding, minimum Hamming distance 3
  typedef enum logic [KmacStW-1:0] {
    KmacIdle     = 6'b001000,
    KmacPrefix   = 6'b100110,
    KmacKeyBlock = 6'b111101,
    KmacMsgFeed  = 6'b010010,
    KmacDigest   = 6'b100001
  } kmac_st_e;

  // Engine phase as reported by the Keccak engine
  typedef enum logic [1:0] {
    StIdle    = 2'b00,
    StAbsorb  = 2'b01,
    StSqueeze = 2'b10
  } sha3_st_e;

  // One-cycle control pulses to the engine
  typedef struct packed {
    logic start;
    logic process;
    logic run;
    logic done;
  } sha3_ctrl_t;

  // Status strobes and phase from the engine
  typedef struct packed {
    logic     block_processed;
    logic     absorbed;
    sha3_st_e phase;
  } engine_stat_t;

  typedef struct packed {
    logic kmac_en;
    logic cshake_en;
  } ctrl_cfg_t;

  // Same layout for enable, test, clear, state and output
  typedef struct packed {
    logic kmac_done;
    logic fifo_empty;
    logic kmac_err;
  } intr_vec_t;

endpackage
